// ==== sifh_consts.svh ====
`ifndef SIFH_CONSTS_SVH
`define SIFH_CONSTS_SVH

// timestamp width from the TDC
`define SIFH_TS_BITS 12

// histogram bins per pixel, taken from the timestamp msbs
`define SIFH_BIN_BITS 4

`define SIFH_PIXELS 4
`define SIFH_PIX_BITS 2

// acquisition shape
`define SIFH_SAMPLES_PER_PIXEL 2
`define SIFH_ACQ_NUM 8

// saturating bin counter width
`define SIFH_CNT_BITS 8

// bin memory is addressed as {pixel, bin}
`define SIFH_ADDR_BITS (`SIFH_PIX_BITS + `SIFH_BIN_BITS)
`define SIFH_DEPTH (`SIFH_PIXELS << `SIFH_BIN_BITS)

`endif

// ==== sifh_ctrl_pkg.sv ====
package sifh_ctrl_pkg;

    // top level FSM states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUILD,
        ST_SEARCH,
        ST_CLEAR
    } sifh_state_e;

    // bin memory access per cycle
    typedef enum logic [1:0] {
        OP_NONE,
        OP_INC,
        OP_READ,
        OP_CLEAR
    } mem_op_e;

endpackage

// ==== sifh_data_pkg.sv ====
`include "sifh_consts.svh"

package sifh_data_pkg;

    // raw photon timestamp
    typedef logic [`SIFH_TS_BITS-1:0] ts_t;

    // histogram bin index
    typedef logic [`SIFH_BIN_BITS-1:0] bin_t;

    // pixel index in the array
    typedef logic [`SIFH_PIX_BITS-1:0] pix_t;

    // bin count, saturating
    typedef logic [`SIFH_CNT_BITS-1:0] cnt_t;

endpackage

// ==== sifh_ctrl.sv ====
`timescale 1ns/1ps
`include "sifh_consts.svh"

module sifh_ctrl (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   sample_valid,
    input  sifh_data_pkg::ts_t     sample_ts,
    output sifh_ctrl_pkg::mem_op_e mem_op,
    output sifh_data_pkg::pix_t    mem_pixel,
    output sifh_data_pkg::bin_t    mem_bin,
    output sifh_data_pkg::ts_t     mem_ts,
    output logic                   scan_first,
    output logic                   scan_last,
    output sifh_data_pkg::pix_t    scan_pixel,
    output logic                   busy,
    output logic                   acq_done,
    output sifh_data_pkg::cnt_t    dropped_count
);
    import sifh_ctrl_pkg::*;
    import sifh_data_pkg::*;

    localparam int SAMP_W  = (`SIFH_SAMPLES_PER_PIXEL > 1) ? $clog2(`SIFH_SAMPLES_PER_PIXEL) : 1;
    localparam int SWEEP_W = (`SIFH_ACQ_NUM > 1) ? $clog2(`SIFH_ACQ_NUM) : 1;
    localparam int ADDR_W  = `SIFH_ADDR_BITS;

    sifh_state_e        state;
    logic [SAMP_W-1:0]  samp_cnt;
    pix_t               pix_cnt;
    logic [SWEEP_W-1:0] sweep_cnt;
    logic [ADDR_W-1:0]  walk_addr;
    logic               drain;
    logic               init_pending;

    logic               accept;
    logic               last_sample;
    logic               walk_end;

    // samples are only taken while building, or to start a build
    assign accept = sample_valid &&
                    ((state == ST_BUILD) || (state == ST_IDLE && !init_pending));

    assign last_sample = (samp_cnt == SAMP_W'(`SIFH_SAMPLES_PER_PIXEL - 1)) &&
                         (pix_cnt == pix_t'(`SIFH_PIXELS - 1)) &&
                         (sweep_cnt == SWEEP_W'(`SIFH_ACQ_NUM - 1));

    assign walk_end = (walk_addr == {ADDR_W{1'b1}});

    // round robin arrival order: sample, then pixel, then sweep
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            samp_cnt  <= '0;
            pix_cnt   <= '0;
            sweep_cnt <= '0;
        end else if (accept) begin
            if (samp_cnt == SAMP_W'(`SIFH_SAMPLES_PER_PIXEL - 1)) begin
                samp_cnt <= '0;
                if (pix_cnt == pix_t'(`SIFH_PIXELS - 1)) begin
                    pix_cnt <= '0;
                    if (sweep_cnt == SWEEP_W'(`SIFH_ACQ_NUM - 1)) begin
                        sweep_cnt <= '0;
                    end else begin
                        sweep_cnt <= sweep_cnt + 1'b1;
                    end
                end else begin
                    pix_cnt <= pix_cnt + 1'b1;
                end
            end else begin
                samp_cnt <= samp_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state        <= ST_IDLE;
            walk_addr    <= '0;
            drain        <= 1'b0;
            init_pending <= 1'b1;
        end else begin
            case (state)
                ST_IDLE, ST_BUILD: begin
                    if (state == ST_IDLE && init_pending) begin
                        state <= ST_CLEAR;
                    end else if (accept) begin
                        if (last_sample) begin
                            state <= ST_SEARCH;
                            drain <= 1'b1;
                        end else begin
                            state <= ST_BUILD;
                        end
                    end
                end
                ST_SEARCH: begin
                    // one idle cycle lets the last increment land before the scan
                    if (drain) begin
                        drain <= 1'b0;
                    end else begin
                        walk_addr <= walk_addr + 1'b1;
                        if (walk_end) begin
                            state <= ST_CLEAR;
                        end
                    end
                end
                ST_CLEAR: begin
                    // walk address wraps back to zero at the end
                    walk_addr <= walk_addr + 1'b1;
                    if (walk_end) begin
                        state        <= ST_IDLE;
                        init_pending <= 1'b0;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_comb begin
        mem_op = OP_NONE;
        case (state)
            ST_IDLE, ST_BUILD: begin
                if (accept) begin
                    mem_op = OP_INC;
                end
            end
            ST_SEARCH: begin
                if (!drain) begin
                    mem_op = OP_READ;
                end
            end
            ST_CLEAR: begin
                mem_op = OP_CLEAR;
            end
            default: begin
                mem_op = OP_NONE;
            end
        endcase
    end

    assign mem_pixel  = (state == ST_SEARCH || state == ST_CLEAR) ?
                        walk_addr[ADDR_W-1 -: `SIFH_PIX_BITS] : pix_cnt;
    assign mem_bin    = walk_addr[`SIFH_BIN_BITS-1:0];
    assign mem_ts     = sample_ts;

    assign scan_pixel = walk_addr[ADDR_W-1 -: `SIFH_PIX_BITS];
    assign scan_first = (mem_op == OP_READ) && (mem_bin == '0);
    assign scan_last  = (mem_op == OP_READ) && (mem_bin == '1);

    assign busy     = (state != ST_IDLE);
    // the clear after reset is not an acquisition
    assign acq_done = (state == ST_CLEAR) && walk_end && !init_pending;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            dropped_count <= '0;
        end else if (sample_valid && !accept && dropped_count != '1) begin
            dropped_count <= dropped_count + 1'b1;
        end
    end

    a_scan_flags: assert property (@(posedge clk) disable iff (!res)
        !(scan_first && scan_last));

    a_idle_quiet: assert property (@(posedge clk) disable iff (!res)
        (state == ST_IDLE && !sample_valid) |-> (mem_op == OP_NONE));

endmodule

// ==== hist_accum.sv ====
`timescale 1ns/1ps
`include "sifh_consts.svh"

module hist_accum (
    input  logic                   clk,
    input  logic                   res,
    input  sifh_ctrl_pkg::mem_op_e mem_op,
    input  sifh_data_pkg::pix_t    mem_pixel,
    input  sifh_data_pkg::bin_t    mem_bin,
    input  sifh_data_pkg::ts_t     mem_ts,
    output logic                   rd_valid,
    output sifh_data_pkg::cnt_t    rd_count
);
    import sifh_ctrl_pkg::*;
    import sifh_data_pkg::*;

    localparam int ADDR_W = `SIFH_ADDR_BITS;

    cnt_t              mem [`SIFH_DEPTH];

    logic [ADDR_W-1:0] inc_addr;
    logic [ADDR_W-1:0] scan_addr;
    cnt_t              cur_count;
    cnt_t              next_count;

    // write-back stage
    logic              wr_pend;
    logic [ADDR_W-1:0] wr_addr;
    cnt_t              wr_val;

    // increments bin on the timestamp msbs
    assign inc_addr  = {mem_pixel, mem_ts[`SIFH_TS_BITS-1 -: `SIFH_BIN_BITS]};
    assign scan_addr = {mem_pixel, mem_bin};

    // back to back hits on one bin see the value still in write-back
    assign cur_count  = (wr_pend && wr_addr == inc_addr) ? wr_val : mem[inc_addr];
    assign next_count = (cur_count == '1) ? cur_count : cur_count + 1'b1;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wr_pend  <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            wr_pend  <= (mem_op == OP_INC);
            rd_valid <= (mem_op == OP_READ);
        end
    end

    always_ff @(posedge clk) begin
        if (mem_op == OP_INC) begin
            wr_addr <= inc_addr;
            wr_val  <= next_count;
        end
        if (mem_op == OP_READ) begin
            rd_count <= mem[scan_addr];
        end
    end

    // single write port shared by write-back and clear
    always_ff @(posedge clk) begin
        if (wr_pend) begin
            mem[wr_addr] <= wr_val;
        end else if (mem_op == OP_CLEAR) begin
            mem[scan_addr] <= '0;
        end
    end

    a_read_no_hazard: assert property (@(posedge clk) disable iff (!res)
        (mem_op == OP_READ) |-> !(wr_pend && wr_addr == scan_addr));

    // a clear in the write-back cycle would lose the clear
    a_clear_no_pend: assert property (@(posedge clk) disable iff (!res)
        (mem_op == OP_CLEAR) |-> !wr_pend);

endmodule

// ==== peak_search.sv ====
`timescale 1ns/1ps

module peak_search (
    input  logic                clk,
    input  logic                res,
    input  logic                rd_valid,
    input  sifh_data_pkg::cnt_t rd_count,
    input  logic                scan_first,
    input  logic                scan_last,
    input  sifh_data_pkg::pix_t scan_pixel,
    output logic                res_valid,
    output sifh_data_pkg::pix_t res_pixel,
    output sifh_data_pkg::bin_t res_bin,
    output sifh_data_pkg::cnt_t res_count
);
    import sifh_data_pkg::*;

    // scan tags delayed to meet the read data
    logic first_q;
    logic last_q;
    pix_t pix_q;

    cnt_t max_count;
    bin_t max_bin;
    bin_t bin_pos;

    bin_t cur_bin;
    logic take;
    cnt_t cand_count;
    bin_t cand_bin;

    assign cur_bin = first_q ? '0 : bin_pos;
    // strict compare keeps the lower bin on a tie
    assign take       = first_q || (rd_count > max_count);
    assign cand_count = take ? rd_count : max_count;
    assign cand_bin   = take ? cur_bin : max_bin;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            first_q   <= 1'b0;
            last_q    <= 1'b0;
            res_valid <= 1'b0;
            max_count <= '0;
            max_bin   <= '0;
            bin_pos   <= '0;
        end else begin
            first_q   <= scan_first;
            last_q    <= scan_last;
            res_valid <= rd_valid && last_q;
            if (rd_valid) begin
                max_count <= cand_count;
                max_bin   <= cand_bin;
                bin_pos   <= cur_bin + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        pix_q <= scan_pixel;
        if (rd_valid && last_q) begin
            res_pixel <= pix_q;
            res_bin   <= cand_bin;
            res_count <= cand_count;
        end
    end

    a_last_has_data: assert property (@(posedge clk) disable iff (!res)
        last_q |-> rd_valid);

endmodule

// ==== sifh_top.sv ====
`timescale 1ns/1ps

module sifh_top (
    input  logic                clk,
    input  logic                res,
    input  logic                sample_valid,
    input  sifh_data_pkg::ts_t  sample_ts,
    output logic                res_valid,
    output sifh_data_pkg::pix_t res_pixel,
    output sifh_data_pkg::bin_t res_bin,
    output sifh_data_pkg::cnt_t res_count,
    output logic                busy,
    output logic                acq_done,
    output sifh_data_pkg::cnt_t dropped_count
);
    import sifh_ctrl_pkg::*;
    import sifh_data_pkg::*;

    mem_op_e mem_op;
    pix_t    mem_pixel;
    bin_t    mem_bin;
    ts_t     mem_ts;
    logic    scan_first;
    logic    scan_last;
    pix_t    scan_pixel;
    logic    rd_valid;
    cnt_t    rd_count;

    sifh_ctrl u_ctrl (
        .clk           (clk),
        .res           (res),
        .sample_valid  (sample_valid),
        .sample_ts     (sample_ts),
        .mem_op        (mem_op),
        .mem_pixel     (mem_pixel),
        .mem_bin       (mem_bin),
        .mem_ts        (mem_ts),
        .scan_first    (scan_first),
        .scan_last     (scan_last),
        .scan_pixel    (scan_pixel),
        .busy          (busy),
        .acq_done      (acq_done),
        .dropped_count (dropped_count)
    );

    hist_accum u_hist (
        .clk       (clk),
        .res       (res),
        .mem_op    (mem_op),
        .mem_pixel (mem_pixel),
        .mem_bin   (mem_bin),
        .mem_ts    (mem_ts),
        .rd_valid  (rd_valid),
        .rd_count  (rd_count)
    );

    peak_search u_peak (
        .clk        (clk),
        .res        (res),
        .rd_valid   (rd_valid),
        .rd_count   (rd_count),
        .scan_first (scan_first),
        .scan_last  (scan_last),
        .scan_pixel (scan_pixel),
        .res_valid  (res_valid),
        .res_pixel  (res_pixel),
        .res_bin    (res_bin),
        .res_count  (res_count)
    );

endmodule

// ==== tb_sifh.sv ====
`timescale 1ns/1ps
`include "sifh_consts.svh"

module tb_sifh;
    import sifh_data_pkg::*;

    localparam int ACQ_SAMPLES  = `SIFH_SAMPLES_PER_PIXEL * `SIFH_PIXELS * `SIFH_ACQ_NUM;
    localparam int ACQ_WORDS    = ACQ_SAMPLES + 2 * `SIFH_PIXELS;
    localparam int WAIT_LIMIT   = 1000;
    localparam int DROP_STROBES = 5;

    logic clk;
    logic res;
    logic sample_valid;
    ts_t  sample_ts;
    logic res_valid;
    pix_t res_pixel;
    bin_t res_bin;
    cnt_t res_count;
    logic busy;
    logic acq_done;
    cnt_t dropped_count;

    // two acquisitions, each 64 timestamps then peak bin and count per pixel
    ts_t stim_mem [2 * ACQ_WORDS];

    int checks       = 0;
    int errors       = 0;
    int tests_failed = 0;
    int res_seen     = 0;
    int done_seen    = 0;
    int drops_sent   = 0;

    sifh_top UUT (
        .clk           (clk),
        .res           (res),
        .sample_valid  (sample_valid),
        .sample_ts     (sample_ts),
        .res_valid     (res_valid),
        .res_pixel     (res_pixel),
        .res_bin       (res_bin),
        .res_count     (res_count),
        .busy          (busy),
        .acq_done      (acq_done),
        .dropped_count (dropped_count)
    );

    always #5 clk = ~clk;

    // strobe counters over the whole run
    always @(posedge clk) begin
        if (res_valid) begin
            res_seen <= res_seen + 1;
        end
        if (acq_done) begin
            done_seen <= done_seen + 1;
        end
    end

    task automatic check_bin(input string name, input bin_t act, input bin_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s: expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input cnt_t act, input cnt_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s: expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_pix(input string name, input pix_t act, input pix_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s: expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s: expected %b, got %b", $time, name, exp, act);
        end
    endtask

    // sel 0 result strobe, 1 acq_done, 2 busy high, 3 busy low
    task automatic wait_for(input int sel, input string what, output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < WAIT_LIMIT && !ok; n++) begin
            @(posedge clk);
            case (sel)
                0: ok = res_valid;
                1: ok = acq_done;
                2: ok = busy;
                default: ok = !busy;
            endcase
        end
        if (!ok) begin
            errors++;
            $display("ERROR t=%0t: timed out waiting for %s", $time, what);
        end
    endtask

    task automatic send_sample(input ts_t ts);
        @(posedge clk);
        sample_valid <= 1'b1;
        sample_ts    <= ts;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            sample_valid <= 1'b0;
        end
    endtask

    task automatic run_acquisition(input int base, input bit gaps, input int drops);
        int   i;
        int   p;
        int   exp_at;
        bit   ok;
        int   done_start;
        done_start = done_seen;
        for (i = 0; i < ACQ_SAMPLES; i++) begin
            send_sample(stim_mem[base + i]);
            if (gaps) begin
                idle_cycles($urandom_range(3, 0));
            end
        end
        // these arrive while the FSM is already searching
        for (i = 0; i < drops; i++) begin
            send_sample(ts_t'($urandom));
        end
        drops_sent += drops;
        idle_cycles(1);
        for (p = 0; p < `SIFH_PIXELS; p++) begin
            exp_at = base + ACQ_SAMPLES + 2 * p;
            wait_for(0, "the result strobe", ok);
            if (ok) begin
                check_pix("res_pixel", res_pixel, pix_t'(p));
                check_bin("res_bin", res_bin, bin_t'(stim_mem[exp_at]));
                check_count("res_count", res_count, cnt_t'(stim_mem[exp_at + 1]));
            end
        end
        check_flag("acq_done before last result", logic'(done_seen != done_start), 1'b0);
        wait_for(1, "acq_done", ok);
        @(posedge clk);
        check_flag("busy", busy, 1'b0);
        check_count("dropped_count", dropped_count, cnt_t'(drops_sent));
        check_flag("single acq_done", logic'(done_seen == done_start + 1), 1'b1);
    endtask

    task automatic end_test(input int num, input string name, input int err_start);
        if (errors == err_start) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, errors - err_start);
        end
    endtask

    initial begin
        int e;
        bit ok;
        void'($urandom(32'h0e8e0ab8));
        clk          = 1'b0;
        res          = 1'b0;
        sample_valid = 1'b0;
        sample_ts    = '0;
        $readmemh("sifh_stim.txt", stim_mem);
        repeat (2) @(posedge clk);
        res <= 1'b1;

        e = errors;
        wait_for(2, "busy in the clear after reset", ok);
        wait_for(3, "the end of the clear after reset", ok);
        @(posedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("res_valid seen", logic'(res_seen != 0), 1'b0);
        check_flag("acq_done seen", logic'(done_seen != 0), 1'b0);
        check_count("dropped_count", dropped_count, '0);
        end_test(1, "reset and initial clear", e);

        idle_cycles(3);
        e = errors;
        run_acquisition(0, 1'b0, 0);
        end_test(2, "back-to-back acquisition", e);

        e = errors;
        run_acquisition(ACQ_WORDS, 1'b1, 0);
        end_test(3, "acquisition with gaps and a tie", e);

        e = errors;
        run_acquisition(0, 1'b0, DROP_STROBES);
        end_test(4, "strobes dropped while busy", e);

        e = errors;
        idle_cycles(2);
        check_flag("acq_done count", logic'(done_seen == 3), 1'b1);
        check_flag("result count", logic'(res_seen == 3 * `SIFH_PIXELS), 1'b1);
        check_flag("busy", busy, 1'b0);
        end_test(5, "acq_done once per acquisition", e);

        $display("tests: 5 run, %0d failing, checks: %0d, errors: %0d",
                 tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== sifh_stim.txt ====
// acquisition A: one sweep per line, columns are pixel 0, 0, 1, 1, 2, 2, 3, 3
// the bin is the top hex digit of each timestamp
312 3a7 a05 4c1 01e 0f3 f80 96d
355 3e0 a9b a42 077 8b4 2d1 f2c
308 3c9 6a3 a1f 0d0 05a fe6 93b
1b2 574 a60 2ef 84d 0c8 c17 f95
2a6 73d 4f2 659 0e1 d08 9ca 53e
581 9b7 82c b14 8f9 36a 240 cd3
1e5 c46 4b9 e72 d1c 7a8 60f 0e4
50d 0f8 693 1c6 85b fb1 b2a e57
// acquisition A expected: peak bin, peak count for pixels 0 to 3
003 006
00a 005
000 007
00f 004
// acquisition B: same column layout, ties on pixels 0 and 2
91c 247 70a 3d5 e62 4b0 619 6f3
5e8 93a 726 781 b0f 0c4 65d 6a2
2b9 01d a47 3e3 890 ed6 60b 6c8
c35 9f1 17e 750 48a 6b2 6e4 637
506 2da 3c1 d4f b99 b23 6b8 60e
f7b 962 a15 7c9 0a3 86e 6f0 64d
0d7 5a8 3f2 18b 654 e0c 62e 691
2e3 c16 d7d a58 1c0 49f 6a4 67a
// acquisition B expected: peak bin, peak count for pixels 0 to 3
002 004
007 005
004 003
006 010

// ==== files.f ====
+incdir+.
sifh_ctrl_pkg.sv
sifh_data_pkg.sv
sifh_ctrl.sv
hist_accum.sv
peak_search.sv
sifh_top.sv
tb_sifh.sv

// ==== Makefile ====
TOP = tb_sifh

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f files.f --top-module $(TOP) -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
